//--- verilog/pcie_cfg_types_pkg.sv
`default_nettype none

package pcie_cfg_types_pkg;

  localparam int cfg_data_w  = 32;
  localparam int cfg_strb_w  = cfg_data_w / 8;
  localparam int cfg_addr_w  = 16;

  localparam int core_count  = 16;
  localparam int core_w      = 4;

  localparam int host_addr_w = 64;
  localparam int ram_addr_w  = 32;
  localparam int dma_len_w   = 16;
  localparam int dma_tag_w   = 32;

  // Accepted AXI-lite write with a one-cycle en
  typedef struct packed {
    logic [cfg_addr_w-1:0] addr;  // Word aligned byte address
    logic [cfg_data_w-1:0] data;
    logic [cfg_strb_w-1:0] strb;
    logic                  en;
  } reg_wr_t;

  typedef struct packed {
    logic [cfg_addr_w-1:0] addr;
    logic                  en;
  } reg_rd_t;

  typedef struct packed {
    logic [host_addr_w-1:0] host_addr;
    logic [ram_addr_w-1:0]  ram_addr;
    logic [dma_len_w-1:0]   len;
    logic [dma_tag_w-1:0]   tag;
  } dma_desc_t;

  typedef struct packed {
    logic [core_w-1:0] dest;
    logic              value;  // Reset level for the core
  } core_reset_cmd_t;

  typedef struct packed {
    logic sfp_scl;
    logic sfp1_sda;
    logic sfp2_sda;
    logic eeprom_scl;
    logic eeprom_sda;
  } i2c_lines_t;

endpackage

`default_nettype wire

//--- verilog/pcie_cfg_map_pkg.sv
`default_nettype none

package pcie_cfg_map_pkg;

  import pcie_cfg_types_pkg::*;

  // Identification block
  localparam logic [cfg_addr_w-1:0] fw_id_addr          = 16'h0000;
  localparam logic [cfg_addr_w-1:0] fw_ver_addr         = 16'h0004;
  localparam logic [cfg_addr_w-1:0] board_id_addr       = 16'h0008;
  localparam logic [cfg_addr_w-1:0] board_ver_addr      = 16'h000C;
  localparam logic [cfg_addr_w-1:0] phc_offset_addr     = 16'h0014;
  localparam logic [cfg_addr_w-1:0] phc_stride_addr     = 16'h0018;
  localparam logic [cfg_addr_w-1:0] if_count_addr       = 16'h0020;
  localparam logic [cfg_addr_w-1:0] if_stride_addr      = 16'h0024;
  localparam logic [cfg_addr_w-1:0] if_ctrl_offset_addr = 16'h002C;
  localparam logic [cfg_addr_w-1:0] fpga_id_addr        = 16'h0040;

  localparam logic [cfg_data_w-1:0] fw_id          = 32'h0000_0000;
  localparam logic [cfg_data_w-1:0] fw_ver         = {16'd0, 16'd1};
  localparam logic [cfg_data_w-1:0] board_id       = {16'h1ce4, 16'h0003};
  localparam logic [cfg_data_w-1:0] board_ver      = {16'd0, 16'd1};
  localparam logic [cfg_data_w-1:0] phc_offset     = 32'h0000_0200;
  localparam logic [cfg_data_w-1:0] phc_stride     = 32'h0000_0080;
  localparam logic [cfg_data_w-1:0] if_count       = 32'd2;
  localparam logic [cfg_data_w-1:0] if_stride      = 32'h8000_0000;  // Two interfaces in 32-bit space
  localparam logic [cfg_data_w-1:0] if_ctrl_offset = 32'h0400_0000;
  localparam logic [cfg_data_w-1:0] fpga_id        = 32'h0382_3093;

  // GPIO
  localparam logic [cfg_addr_w-1:0] gpio_out_addr   = 16'h0100;
  localparam logic [cfg_addr_w-1:0] gpio_in_addr    = 16'h0104;
  localparam int                    gpio_sfp_lsb    = 16;  // scl, sda1, sda2
  localparam int                    gpio_eeprom_lsb = 24;  // scl, sda

  // Core control
  localparam logic [cfg_addr_w-1:0] dma_enable_addr   = 16'h0400;
  localparam logic [cfg_addr_w-1:0] core_reset_addr   = 16'h0404;
  localparam logic [cfg_addr_w-1:0] income_cores_addr = 16'h0408;
  localparam logic [cfg_addr_w-1:0] reset_cores_addr  = 16'h040C;

  // Host DMA channels
  localparam logic [cfg_addr_w-1:0] dma_rd_base     = 16'h0440;
  localparam logic [cfg_addr_w-1:0] dma_wr_base     = 16'h0460;
  localparam logic [cfg_addr_w-1:0] dma_host_lo_off = 16'h0000;
  localparam logic [cfg_addr_w-1:0] dma_host_hi_off = 16'h0004;
  localparam logic [cfg_addr_w-1:0] dma_ram_off     = 16'h0008;
  localparam logic [cfg_addr_w-1:0] dma_len_off     = 16'h0010;
  localparam logic [cfg_addr_w-1:0] dma_tag_off     = 16'h0014;  // Write issues descriptor
  localparam logic [cfg_addr_w-1:0] dma_status_off  = 16'h0018;

endpackage

`default_nettype wire

//--- verilog/cfg_reg_slave.sv
`timescale 1ns/1ns
`default_nettype none

module cfg_reg_slave
  import pcie_cfg_types_pkg::*;
  import pcie_cfg_map_pkg::*;
(
  input  wire                   pcie_clk,
  input  wire                   pcie_rst,

  input  wire  [cfg_addr_w-1:0] awaddr_i,
  input  wire                   awvalid_i,
  output logic                  awready_o,
  input  wire  [cfg_data_w-1:0] wdata_i,
  input  wire  [cfg_strb_w-1:0] wstrb_i,
  input  wire                   wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  wire                   bready_i,
  input  wire  [cfg_addr_w-1:0] araddr_i,
  input  wire                   arvalid_i,
  output logic                  arready_o,
  output logic [cfg_data_w-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  wire                   rready_i,

  output reg_wr_t               reg_wr_o,
  output reg_rd_t               reg_rd_o,

  input  wire  [cfg_data_w-1:0] gpio_rdata_i,
  input  wire  [cfg_data_w-1:0] dma_rd_rdata_i,
  input  wire  [cfg_data_w-1:0] dma_wr_rdata_i,
  input  wire  [cfg_data_w-1:0] core_rdata_i
);

  logic                  wr_acc;
  logic                  rd_acc;
  logic [cfg_data_w-1:0] id_rdata;

  // Only one outstanding response of each kind
  assign wr_acc = awvalid_i && wvalid_i && !bvalid_o;
  assign rd_acc = arvalid_i && !rvalid_o;

  assign reg_wr_o = '{addr: {awaddr_i[cfg_addr_w-1:2], 2'b00},
                      data: wdata_i,
                      strb: wstrb_i,
                      en:   wr_acc};

  assign reg_rd_o = '{addr: {araddr_i[cfg_addr_w-1:2], 2'b00},
                      en:   rd_acc};

  assign bresp_o = 2'b00;  // OKAY
  assign rresp_o = 2'b00;

  always_comb begin
    case (reg_rd_o.addr)
      fw_id_addr:          id_rdata = fw_id;
      fw_ver_addr:         id_rdata = fw_ver;
      board_id_addr:       id_rdata = board_id;
      board_ver_addr:      id_rdata = board_ver;
      phc_offset_addr:     id_rdata = phc_offset;
      phc_stride_addr:     id_rdata = phc_stride;
      if_count_addr:       id_rdata = if_count;
      if_stride_addr:      id_rdata = if_stride;
      if_ctrl_offset_addr: id_rdata = if_ctrl_offset;
      fpga_id_addr:        id_rdata = fpga_id;
      default:             id_rdata = '0;
    endcase
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      awready_o <= wr_acc;
      wready_o  <= wr_acc;
      bvalid_o  <= wr_acc || (bvalid_o && !bready_i);
      arready_o <= rd_acc;
      rvalid_o  <= rd_acc || (rvalid_o && !rready_i);
    end
  end

  // Blocks return zero outside their own range
  always_ff @(posedge pcie_clk) begin
    if (rd_acc) begin
      rdata_o <= id_rdata | gpio_rdata_i | dma_rd_rdata_i | dma_wr_rdata_i | core_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/i2c_gpio_regs.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_gpio_regs
  import pcie_cfg_types_pkg::*;
  import pcie_cfg_map_pkg::*;
(
  input  wire                   pcie_clk,
  input  wire                   pcie_rst,

  input  reg_wr_t               reg_wr_i,
  input  reg_rd_t               reg_rd_i,
  output logic [cfg_data_w-1:0] rdata_o,

  input  i2c_lines_t            i2c_i,
  output i2c_lines_t            i2c_o
);

  i2c_lines_t out_q;  // Firmware image of the pins
  i2c_lines_t in_q;
  logic       out_wr;

  assign out_wr = reg_wr_i.en && (reg_wr_i.addr == gpio_out_addr);

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      out_q <= '1;  // Lines released
    end else if (out_wr) begin
      if (reg_wr_i.strb[2]) begin
        out_q.sfp_scl  <= reg_wr_i.data[gpio_sfp_lsb];
        out_q.sfp1_sda <= reg_wr_i.data[gpio_sfp_lsb+1];
        out_q.sfp2_sda <= reg_wr_i.data[gpio_sfp_lsb+2];
      end
      if (reg_wr_i.strb[3]) begin
        out_q.eeprom_scl <= reg_wr_i.data[gpio_eeprom_lsb];
        out_q.eeprom_sda <= reg_wr_i.data[gpio_eeprom_lsb+1];
      end
    end
  end

  // One register stage on each pin direction for IO timing
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      i2c_o <= '1;
      in_q  <= '1;
    end else begin
      i2c_o <= out_q;
      in_q  <= i2c_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (reg_rd_i.en) begin
      case (reg_rd_i.addr)
        gpio_out_addr: begin
          rdata_o[gpio_sfp_lsb +: 3]    = {out_q.sfp2_sda, out_q.sfp1_sda, out_q.sfp_scl};
          rdata_o[gpio_eeprom_lsb +: 2] = {out_q.eeprom_sda, out_q.eeprom_scl};
        end
        gpio_in_addr: begin
          rdata_o[gpio_sfp_lsb +: 3]    = {in_q.sfp2_sda, in_q.sfp1_sda, in_q.sfp_scl};
          rdata_o[gpio_eeprom_lsb +: 2] = {in_q.eeprom_sda, in_q.eeprom_scl};
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/host_dma_channel.sv
`timescale 1ns/1ns
`default_nettype none

module host_dma_channel
  import pcie_cfg_types_pkg::*;
  import pcie_cfg_map_pkg::*;
#(
  parameter logic [cfg_addr_w-1:0] ch_base = dma_rd_base
) (
  input  wire                   pcie_clk,
  input  wire                   pcie_rst,

  input  reg_wr_t               reg_wr_i,
  input  reg_rd_t               reg_rd_i,
  output logic [cfg_data_w-1:0] rdata_o,

  output dma_desc_t             desc_o,
  output logic                  desc_valid_o,
  input  wire                   desc_ready_i,

  input  wire  [dma_tag_w-1:0]  status_tag_i,
  input  wire                   status_valid_i
);

  localparam logic [cfg_addr_w-1:0] host_lo_addr = ch_base + dma_host_lo_off;
  localparam logic [cfg_addr_w-1:0] host_hi_addr = ch_base + dma_host_hi_off;
  localparam logic [cfg_addr_w-1:0] ram_addr     = ch_base + dma_ram_off;
  localparam logic [cfg_addr_w-1:0] len_addr     = ch_base + dma_len_off;
  localparam logic [cfg_addr_w-1:0] tag_addr     = ch_base + dma_tag_off;
  localparam logic [cfg_addr_w-1:0] status_addr  = ch_base + dma_status_off;

  logic [dma_tag_w-1:0] status_q;  // Completed tags since last read
  logic                 issue;
  logic                 status_rd;

  assign issue     = reg_wr_i.en && (reg_wr_i.addr == tag_addr);
  assign status_rd = reg_rd_i.en && (reg_rd_i.addr == status_addr);

  always_ff @(posedge pcie_clk) begin
    if (reg_wr_i.en) begin
      case (reg_wr_i.addr)
        host_lo_addr: desc_o.host_addr[cfg_data_w-1:0]           <= reg_wr_i.data;
        host_hi_addr: desc_o.host_addr[host_addr_w-1:cfg_data_w] <= reg_wr_i.data;
        ram_addr:     desc_o.ram_addr <= reg_wr_i.data[ram_addr_w-1:0];
        len_addr:     desc_o.len      <= reg_wr_i.data[dma_len_w-1:0];
        tag_addr:     desc_o.tag      <= reg_wr_i.data[dma_tag_w-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      desc_valid_o <= 1'b0;
    end else if (issue) begin
      desc_valid_o <= 1'b1;  // Reissue overwrites a pending one
    end else if (desc_ready_i) begin
      desc_valid_o <= 1'b0;
    end
  end

  // Clear on read but keep a tag landing in the same cycle
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      status_q <= '0;
    end else if (status_rd) begin
      status_q <= status_valid_i ? status_tag_i : '0;
    end else if (status_valid_i) begin
      status_q <= status_q | status_tag_i;
    end
  end

  assign rdata_o = status_rd ? status_q : '0;

endmodule

`default_nettype wire

//--- verilog/core_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module core_ctrl_regs
  import pcie_cfg_types_pkg::*;
  import pcie_cfg_map_pkg::*;
(
  input  wire                   pcie_clk,
  input  wire                   pcie_rst,

  input  reg_wr_t               reg_wr_i,
  input  reg_rd_t               reg_rd_i,
  output logic [cfg_data_w-1:0] rdata_o,

  output logic                  pcie_dma_enable_o,
  output logic [core_count-1:0] income_cores_o,
  output logic [core_count-1:0] cores_to_be_reset_o,

  output core_reset_cmd_t       reset_cmd_o,
  output logic                  reset_valid_o,
  input  wire                   reset_ready_i
);

  logic [core_count-1:0] income_q;
  logic                  reset_wr;

  assign reset_wr = reg_wr_i.en && (reg_wr_i.addr == core_reset_addr);

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      pcie_dma_enable_o   <= 1'b1;
      income_q            <= '1;
      cores_to_be_reset_o <= '0;
      income_cores_o      <= '1;
      reset_valid_o       <= 1'b0;
    end else begin
      // A core being reset never takes new traffic
      income_cores_o <= income_q & ~cores_to_be_reset_o;

      if (reset_ready_i) begin
        reset_valid_o <= 1'b0;
      end

      if (reg_wr_i.en) begin
        case (reg_wr_i.addr)
          dma_enable_addr:   pcie_dma_enable_o   <= reg_wr_i.data[0];
          core_reset_addr:   reset_valid_o       <= 1'b1;
          income_cores_addr: income_q            <= reg_wr_i.data[core_count-1:0];
          reset_cores_addr:  cores_to_be_reset_o <= reg_wr_i.data[core_count-1:0];
          default: ;
        endcase
      end
    end
  end

  // Bit 0 of the payload is the reset level
  always_ff @(posedge pcie_clk) begin
    if (reset_wr) begin
      reset_cmd_o <= '{dest:  reg_wr_i.data[core_w:1],
                       value: reg_wr_i.data[0]};
    end
  end

  always_comb begin
    rdata_o = '0;
    if (reg_rd_i.en && (reg_rd_i.addr == dma_enable_addr)) begin
      rdata_o[0] = pcie_dma_enable_o;
    end
  end

endmodule

`default_nettype wire

//--- verilog/pcie_config.sv
`timescale 1ns/1ns
`default_nettype none

module pcie_config
  import pcie_cfg_types_pkg::*;
  import pcie_cfg_map_pkg::*;
(
  input  wire                   pcie_clk,
  input  wire                   pcie_rst,

  input  wire  [cfg_addr_w-1:0] awaddr_i,
  input  wire                   awvalid_i,
  output logic                  awready_o,
  input  wire  [cfg_data_w-1:0] wdata_i,
  input  wire  [cfg_strb_w-1:0] wstrb_i,
  input  wire                   wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  wire                   bready_i,
  input  wire  [cfg_addr_w-1:0] araddr_i,
  input  wire                   arvalid_i,
  output logic                  arready_o,
  output logic [cfg_data_w-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  wire                   rready_i,

  input  i2c_lines_t            i2c_i,
  output i2c_lines_t            i2c_o,

  output dma_desc_t             dma_rd_desc_o,
  output logic                  dma_rd_desc_valid_o,
  input  wire                   dma_rd_desc_ready_i,
  input  wire  [dma_tag_w-1:0]  dma_rd_status_tag_i,
  input  wire                   dma_rd_status_valid_i,

  output dma_desc_t             dma_wr_desc_o,
  output logic                  dma_wr_desc_valid_o,
  input  wire                   dma_wr_desc_ready_i,
  input  wire  [dma_tag_w-1:0]  dma_wr_status_tag_i,
  input  wire                   dma_wr_status_valid_i,

  output logic                  pcie_dma_enable_o,
  output logic [core_count-1:0] income_cores_o,
  output logic [core_count-1:0] cores_to_be_reset_o,
  output core_reset_cmd_t       reset_cmd_o,
  output logic                  reset_valid_o,
  input  wire                   reset_ready_i
);

  reg_wr_t               reg_wr;
  reg_rd_t               reg_rd;
  logic [cfg_data_w-1:0] gpio_rdata;
  logic [cfg_data_w-1:0] dma_rd_rdata;
  logic [cfg_data_w-1:0] dma_wr_rdata;
  logic [cfg_data_w-1:0] core_rdata;

  cfg_reg_slave cfg_reg_slave_i (
    .pcie_clk, .pcie_rst,
    .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o, .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .reg_wr_o       (reg_wr),
    .reg_rd_o       (reg_rd),
    .gpio_rdata_i   (gpio_rdata),
    .dma_rd_rdata_i (dma_rd_rdata),
    .dma_wr_rdata_i (dma_wr_rdata),
    .core_rdata_i   (core_rdata)
  );

  i2c_gpio_regs i2c_gpio_regs_i (
    .pcie_clk, .pcie_rst,
    .reg_wr_i (reg_wr),
    .reg_rd_i (reg_rd),
    .rdata_o  (gpio_rdata),
    .i2c_i,
    .i2c_o
  );

  host_dma_channel #(.ch_base(dma_rd_base)) dma_rd_ch (
    .pcie_clk, .pcie_rst,
    .reg_wr_i       (reg_wr),
    .reg_rd_i       (reg_rd),
    .rdata_o        (dma_rd_rdata),
    .desc_o         (dma_rd_desc_o),
    .desc_valid_o   (dma_rd_desc_valid_o),
    .desc_ready_i   (dma_rd_desc_ready_i),
    .status_tag_i   (dma_rd_status_tag_i),
    .status_valid_i (dma_rd_status_valid_i)
  );

  host_dma_channel #(.ch_base(dma_wr_base)) dma_wr_ch (
    .pcie_clk, .pcie_rst,
    .reg_wr_i       (reg_wr),
    .reg_rd_i       (reg_rd),
    .rdata_o        (dma_wr_rdata),
    .desc_o         (dma_wr_desc_o),
    .desc_valid_o   (dma_wr_desc_valid_o),
    .desc_ready_i   (dma_wr_desc_ready_i),
    .status_tag_i   (dma_wr_status_tag_i),
    .status_valid_i (dma_wr_status_valid_i)
  );

  core_ctrl_regs core_ctrl_regs_i (
    .pcie_clk, .pcie_rst,
    .reg_wr_i (reg_wr),
    .reg_rd_i (reg_rd),
    .rdata_o  (core_rdata),
    .pcie_dma_enable_o,
    .income_cores_o,
    .cores_to_be_reset_o,
    .reset_cmd_o,
    .reset_valid_o,
    .reset_ready_i
  );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/pcie_config_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module pcie_config_asserts (
  input wire pcie_clk,
  input wire pcie_rst,
  input wire awready_o,
  input wire bvalid_o,
  input wire bready_i,
  input wire rvalid_o,
  input wire rready_i
);

  int assert_fails = 0;

  bvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    bvalid_o && !bready_i |=> bvalid_o)
    else begin
      $error("bvalid dropped before bready");
      assert_fails++;
    end

  // awready is a one cycle pulse that comes with a new response
  awready_pulse: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    awready_o |-> bvalid_o ##1 !awready_o)
    else begin
      $error("awready is not a single pulse with bvalid");
      assert_fails++;
    end

  rvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rvalid_o && !rready_i |=> rvalid_o)
    else begin
      $error("rvalid dropped before rready");
      assert_fails++;
    end

endmodule

`default_nettype wire

//--- dv/pcie_config_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pcie_config_tb
  import pcie_cfg_types_pkg::*;
  import pcie_cfg_map_pkg::*;
;

  localparam int wait_limit = 200;
  localparam int check_w = $bits(dma_desc_t);

  logic pcie_clk, pcie_rst;
  logic [cfg_addr_w-1:0] awaddr, araddr;
  logic [cfg_data_w-1:0] wdata, rdata;
  logic [cfg_strb_w-1:0] wstrb;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;
  i2c_lines_t i2c_in, i2c_out;
  dma_desc_t rd_desc, wr_desc;
  logic rd_desc_valid, rd_desc_ready, wr_desc_valid, wr_desc_ready;
  logic [dma_tag_w-1:0] rd_status_tag, wr_status_tag;
  logic rd_status_valid, wr_status_valid;
  logic dma_enable;
  logic [core_count-1:0] income_cores, reset_cores;
  core_reset_cmd_t reset_cmd;
  logic reset_valid, reset_ready;

  integer seed = 32'h84600f4c;
  logic [31:0] rnd;
  int check_errors = 0;
  int protocol_errors = 0;

  // Register model
  logic [cfg_data_w-1:0] m_gpio_out = 32'h0307_0000;
  i2c_lines_t m_i2c_in = '1;
  logic m_dma_en = 1'b1;
  logic [dma_tag_w-1:0] m_status_rd = '0;
  logic [dma_tag_w-1:0] m_status_wr = '0;

  string exp_name_q[$];
  logic [cfg_data_w-1:0] exp_data_q[$];
  dma_desc_t exp_rd_desc_q[$];
  dma_desc_t exp_wr_desc_q[$];
  core_reset_cmd_t exp_cmd_q[$];
  int rd_hs = 0;
  int wr_hs = 0;
  int cmd_hs = 0;
  logic [2:0] last_v = '0;
  logic [2:0] last_r = '0;
  logic last_wacc = 1'b0;
  logic last_racc = 1'b0;

  tb_clk_gen tb_clk_gen_i (.clk_o(pcie_clk), .rst_o(pcie_rst));

  bind cfg_reg_slave pcie_config_asserts pcie_config_asserts_i (.*);

  pcie_config pcie_config_i (
    .pcie_clk, .pcie_rst,
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
    .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready),
    .i2c_i(i2c_in), .i2c_o(i2c_out),
    .dma_rd_desc_o(rd_desc), .dma_rd_desc_valid_o(rd_desc_valid),
    .dma_rd_desc_ready_i(rd_desc_ready),
    .dma_rd_status_tag_i(rd_status_tag), .dma_rd_status_valid_i(rd_status_valid),
    .dma_wr_desc_o(wr_desc), .dma_wr_desc_valid_o(wr_desc_valid),
    .dma_wr_desc_ready_i(wr_desc_ready),
    .dma_wr_status_tag_i(wr_status_tag), .dma_wr_status_valid_i(wr_status_valid),
    .pcie_dma_enable_o(dma_enable), .income_cores_o(income_cores),
    .cores_to_be_reset_o(reset_cores), .reset_cmd_o(reset_cmd),
    .reset_valid_o(reset_valid), .reset_ready_i(reset_ready)
  );

  function automatic logic [cfg_data_w-1:0] lines_word(input i2c_lines_t l);
    logic [cfg_data_w-1:0] w;
    w = '0;
    w[gpio_sfp_lsb]      = l.sfp_scl;
    w[gpio_sfp_lsb+1]    = l.sfp1_sda;
    w[gpio_sfp_lsb+2]    = l.sfp2_sda;
    w[gpio_eeprom_lsb]   = l.eeprom_scl;
    w[gpio_eeprom_lsb+1] = l.eeprom_sda;
    return w;
  endfunction

  // Expected read data for the current model state
  function automatic logic [cfg_data_w-1:0] ref_read(input logic [cfg_addr_w-1:0] addr);
    case (addr)
      fw_id_addr:                   return fw_id;
      fw_ver_addr:                  return fw_ver;
      board_id_addr:                return board_id;
      board_ver_addr:               return board_ver;
      phc_offset_addr:              return phc_offset;
      phc_stride_addr:              return phc_stride;
      if_count_addr:                return if_count;
      if_stride_addr:               return if_stride;
      if_ctrl_offset_addr:          return if_ctrl_offset;
      fpga_id_addr:                 return fpga_id;
      gpio_out_addr:                return m_gpio_out;
      gpio_in_addr:                 return lines_word(m_i2c_in);
      dma_enable_addr:              return {31'd0, m_dma_en};
      dma_rd_base + dma_status_off: return m_status_rd;
      dma_wr_base + dma_status_off: return m_status_wr;
      default:                      return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [check_w-1:0] exp,
                             input logic [check_w-1:0] act);
    assert (act === exp) else begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      check_errors++;
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic write_reg(input logic [cfg_addr_w-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int n;
    n = 0;
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do begin
      @(posedge pcie_clk);
      if (++n > wait_limit) timeout_abort("write acceptance");
    end while (bvalid);  // Accepted at the edge that sees bvalid low
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (addr == gpio_out_addr && strb[2]) m_gpio_out[gpio_sfp_lsb +: 3] = data[gpio_sfp_lsb +: 3];
    if (addr == gpio_out_addr && strb[3])
      m_gpio_out[gpio_eeprom_lsb +: 2] = data[gpio_eeprom_lsb +: 2];
    if (addr == dma_enable_addr) m_dma_en = data[0];
    n = 0;
    do begin
      @(posedge pcie_clk);
      if (++n > wait_limit) timeout_abort("write response");
    end while (!(bvalid && bready));
  endtask

  // Optional status tag on the read channel at the read acceptance edge
  task automatic read_check(input string name, input logic [cfg_addr_w-1:0] addr,
                            input logic inject, input logic [dma_tag_w-1:0] tag);
    int n;
    n = 0;
    exp_name_q.push_back(name);
    exp_data_q.push_back(ref_read(addr));
    if (addr == dma_rd_base + dma_status_off) m_status_rd = inject ? tag : '0;
    if (addr == dma_wr_base + dma_status_off) m_status_wr = '0;
    araddr  <= addr;
    arvalid <= 1'b1;
    if (inject) begin
      rd_status_tag   <= tag;
      rd_status_valid <= 1'b1;
    end
    do begin
      @(posedge pcie_clk);
      if (++n > wait_limit) timeout_abort("read acceptance");
    end while (rvalid);
    arvalid         <= 1'b0;
    rd_status_valid <= 1'b0;
    n = 0;
    do begin
      @(posedge pcie_clk);
      if (++n > wait_limit) timeout_abort("read response");
    end while (!(rvalid && rready));
  endtask

  task automatic status_pulse(input bit wr_ch, input logic [dma_tag_w-1:0] tag);
    if (wr_ch) begin
      wr_status_tag   <= tag;
      wr_status_valid <= 1'b1;
      m_status_wr = m_status_wr | tag;
    end else begin
      rd_status_tag   <= tag;
      rd_status_valid <= 1'b1;
      m_status_rd = m_status_rd | tag;
    end
    @(posedge pcie_clk);
    rd_status_valid <= 1'b0;
    wr_status_valid <= 1'b0;
  endtask

  task automatic issue_desc(input logic [cfg_addr_w-1:0] base, input dma_desc_t d);
    if (base == dma_rd_base) exp_rd_desc_q.push_back(d);
    else exp_wr_desc_q.push_back(d);
    write_reg(base + dma_host_lo_off, d.host_addr[31:0], 4'hF);
    write_reg(base + dma_host_hi_off, d.host_addr[63:32], 4'hF);
    write_reg(base + dma_ram_off, d.ram_addr, 4'hF);
    write_reg(base + dma_len_off, {16'd0, d.len}, 4'hF);
    write_reg(base + dma_tag_off, d.tag, 4'hF);
  endtask

  task automatic wait_handshakes(input int rd_n, input int wr_n, input int cmd_n);
    int n;
    n = 0;
    while (rd_hs < rd_n || wr_hs < wr_n || cmd_hs < cmd_n) begin
      @(posedge pcie_clk);
      if (++n > wait_limit) timeout_abort("descriptor or reset command handshake");
    end
  endtask

  task automatic hold_check(input string name, input logic lv, input logic lr, input logic v);
    assert (!(lv && !lr && !v)) else begin
      $display("%s valid dropped without a ready", name);
      protocol_errors++;
    end
  endtask

  // Random back-pressure
  always @(posedge pcie_clk) begin
    rnd = $random(seed);
    bready        <= rnd[0];
    rready        <= rnd[1];
    rd_desc_ready <= rnd[2];
    wr_desc_ready <= rnd[3];
    reset_ready   <= rnd[4];
  end

  // Compare responses and handshakes as they happen
  always @(posedge pcie_clk) begin
    if (!pcie_rst) begin
      check_value("awready", last_wacc, awready);
      check_value("wready", last_wacc, wready);
      check_value("arready", last_racc, arready);
      if (bvalid && bready) check_value("bresp", 2'b00, bresp);
      if (rvalid && rready) begin
        check_value("rresp", 2'b00, rresp);
        assert (exp_name_q.size() != 0) begin
          check_value(exp_name_q.pop_front(), exp_data_q.pop_front(), rdata);
        end else begin
          $display("Read response arrived with no read pending");
          protocol_errors++;
        end
      end
      if (rd_desc_valid && rd_desc_ready) begin
        assert (exp_rd_desc_q.size() != 0) begin
          check_value("dma_rd_desc", exp_rd_desc_q.pop_front(), rd_desc);
        end else begin
          $display("Read channel descriptor taken with none issued");
          protocol_errors++;
        end
        rd_hs++;
      end
      if (wr_desc_valid && wr_desc_ready) begin
        assert (exp_wr_desc_q.size() != 0) begin
          check_value("dma_wr_desc", exp_wr_desc_q.pop_front(), wr_desc);
        end else begin
          $display("Write channel descriptor taken with none issued");
          protocol_errors++;
        end
        wr_hs++;
      end
      if (reset_valid && reset_ready) begin
        assert (exp_cmd_q.size() != 0) begin
          check_value("reset_cmd", exp_cmd_q.pop_front(), reset_cmd);
        end else begin
          $display("Reset command taken with none issued");
          protocol_errors++;
        end
        cmd_hs++;
      end
      hold_check("dma_rd_desc", last_v[0], last_r[0], rd_desc_valid);
      hold_check("dma_wr_desc", last_v[1], last_r[1], wr_desc_valid);
      hold_check("reset_cmd", last_v[2], last_r[2], reset_valid);
    end
    last_v = {reset_valid, wr_desc_valid, rd_desc_valid};
    last_r = {reset_ready, wr_desc_ready, rd_desc_ready};
    last_wacc = !pcie_rst && awvalid && wvalid && !bvalid;
    last_racc = !pcie_rst && arvalid && !rvalid;
  end

  initial begin
    int n;
    int assert_errors;
    awaddr = '0;
    wdata = '0;
    wstrb = '0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    bready = 1'b0;
    rready = 1'b0;
    i2c_in = '1;
    rd_desc_ready = 1'b0;
    wr_desc_ready = 1'b0;
    reset_ready = 1'b0;
    rd_status_tag = '0;
    wr_status_tag = '0;
    rd_status_valid = 1'b0;
    wr_status_valid = 1'b0;
    n = 0;
    do begin
      @(posedge pcie_clk);
      if (++n > wait_limit) timeout_abort("reset release");
    end while (pcie_rst);

    read_check("fw_id", fw_id_addr, 1'b0, '0);
    read_check("fw_ver", fw_ver_addr, 1'b0, '0);
    read_check("board_id", board_id_addr, 1'b0, '0);
    read_check("board_ver", board_ver_addr, 1'b0, '0);
    read_check("phc_offset", phc_offset_addr, 1'b0, '0);
    read_check("phc_stride", phc_stride_addr, 1'b0, '0);
    read_check("if_count", if_count_addr, 1'b0, '0);
    read_check("if_stride", if_stride_addr, 1'b0, '0);
    read_check("if_ctrl_offset", if_ctrl_offset_addr, 1'b0, '0);
    read_check("fpga_id", fpga_id_addr, 1'b0, '0);
    read_check("unmapped", 16'h0200, 1'b0, '0);
    check_value("reset_dma_enable", 1, dma_enable);
    check_value("reset_income", 16'hFFFF, income_cores);

    write_reg(gpio_out_addr, 32'h0005_0000, 4'b0100);
    write_reg(gpio_out_addr, 32'h0100_0000, 4'b1000);
    write_reg(gpio_out_addr, 32'hFFFF_FFFF, 4'b0011);  // No I2C byte enabled
    read_check("gpio_out", gpio_out_addr, 1'b0, '0);
    repeat (2) @(posedge pcie_clk);
    check_value("i2c_o", m_gpio_out, lines_word(i2c_out));
    i2c_in <= 5'b10110;
    m_i2c_in = 5'b10110;
    repeat (2) @(posedge pcie_clk);
    read_check("gpio_in", gpio_in_addr, 1'b0, '0);

    issue_desc(dma_rd_base, '{64'h1234_5678_9ABC_DEF0, 32'h0000_1000, 16'h0040, 32'h0000_0011});
    issue_desc(dma_wr_base, '{64'h0FED_CBA9_8765_4321, 32'h0000_2000, 16'h0100, 32'h0000_0022});
    wait_handshakes(1, 1, 0);

    status_pulse(1'b0, 32'h0000_0011);
    status_pulse(1'b0, 32'h0100_0000);
    status_pulse(1'b1, 32'h0000_00A5);
    read_check("rd_status_or", dma_rd_base + dma_status_off, 1'b0, '0);
    read_check("wr_status_or", dma_wr_base + dma_status_off, 1'b0, '0);
    read_check("rd_status_race", dma_rd_base + dma_status_off, 1'b1, 32'h8000_0000);
    read_check("rd_status_late", dma_rd_base + dma_status_off, 1'b0, '0);
    read_check("rd_status_clear", dma_rd_base + dma_status_off, 1'b0, '0);

    write_reg(income_cores_addr, 32'h0000_F0F0, 4'hF);
    write_reg(reset_cores_addr, 32'h0000_00F0, 4'hF);
    repeat (3) @(posedge pcie_clk);
    check_value("income_cores", 16'hF000, income_cores);
    check_value("cores_to_be_reset", 16'h00F0, reset_cores);
    exp_cmd_q.push_back('{dest: 4'd5, value: 1'b1});
    write_reg(core_reset_addr, 32'h0000_000B, 4'hF);
    wait_handshakes(1, 1, 1);
    write_reg(dma_enable_addr, 32'h0, 4'hF);
    read_check("dma_enable", dma_enable_addr, 1'b0, '0);
    check_value("dma_enable_out", 0, dma_enable);

    assert_errors = pcie_config_i.cfg_reg_slave_i.pcie_config_asserts_i.assert_fails;
    $display("Errors: %0d check, %0d protocol, %0d assertion", check_errors, protocol_errors,
             assert_errors);
    if (check_errors == 0 && protocol_errors == 0 && assert_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
verilog/pcie_cfg_types_pkg.sv
verilog/pcie_cfg_map_pkg.sv
verilog/cfg_reg_slave.sv
verilog/i2c_gpio_regs.sv
verilog/host_dma_channel.sv
verilog/core_ctrl_regs.sv
verilog/pcie_config.sv
dv/tb_clk_gen.sv
dv/pcie_config_asserts.sv
dv/pcie_config_tb.sv

//--- Bender.yml
package:
  name: pcie_config

sources:
  - verilog/pcie_cfg_types_pkg.sv
  - verilog/pcie_cfg_map_pkg.sv
  - verilog/cfg_reg_slave.sv
  - verilog/i2c_gpio_regs.sv
  - verilog/host_dma_channel.sv
  - verilog/core_ctrl_regs.sv
  - verilog/pcie_config.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/pcie_config_asserts.sv
      - dv/pcie_config_tb.sv
